//--- fpRootDivPkg.sv
// *********************************************************************
// shared types and constants for the divide/square-root cluster
// opcode and unit-state enums, field widths, operand class codes
// *********************************************************************

package fpRootDivPkg;

  typedef enum logic [0:0] {
    opDiv,
    opSqrt
  } rtOp_e;

  typedef enum logic [1:0] {
    stIdle,
    stIter,
    stDone
  } unitState_e;

  localparam int TAG_WIDTH  = 10;
  localparam int REG_WIDTH  = 9;
  localparam int MANT_STEPS = 26; // 24 result bits + norm bit + guard bit
  localparam int EXP_WIDTH  = 10; // signed unbiased exponent
  localparam int MANT_WIDTH = 26; // two integer bits, 24 fraction bits

  localparam logic [31:0] QNAN_VALUE = 32'h7FC00000;

  // operand class codes from decode
  localparam int CLASS_WIDTH = 2;
  localparam logic [CLASS_WIDTH-1:0] CLASS_NORMAL  = 2'd0;
  localparam logic [CLASS_WIDTH-1:0] CLASS_DIVZERO = 2'd1;
  localparam logic [CLASS_WIDTH-1:0] CLASS_INVALID = 2'd2;
  localparam logic [CLASS_WIDTH-1:0] CLASS_ZERO    = 2'd3;

endpackage

//--- opQueue.sv
// *********************************************************************
// input FIFO for issued divide/square-root operations
// *********************************************************************

`timescale 1ns/1ps

module opQueue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               flush,
  input  logic                               inEn,
  input  fpRootDivPkg::rtOp_e                inOp,
  input  logic [31:0]                        inA,
  input  logic [31:0]                        inB,
  input  logic [fpRootDivPkg::REG_WIDTH-1:0] inReg,
  input  logic [fpRootDivPkg::TAG_WIDTH-1:0] inTag,
  input  logic                               pop,
  output logic                               queueFull,
  output logic                               headValid,
  output fpRootDivPkg::rtOp_e                headOp,
  output logic [31:0]                        headA,
  output logic [31:0]                        headB,
  output logic [fpRootDivPkg::REG_WIDTH-1:0] headReg,
  output logic [fpRootDivPkg::TAG_WIDTH-1:0] headTag
);
  import fpRootDivPkg::*;

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  rtOp_e                opMem  [QUEUE_DEPTH];
  logic [31:0]          aMem   [QUEUE_DEPTH];
  logic [31:0]          bMem   [QUEUE_DEPTH];
  logic [REG_WIDTH-1:0] regMem [QUEUE_DEPTH];
  logic [TAG_WIDTH-1:0] tagMem [QUEUE_DEPTH];

  logic [PTR_W-1:0] wrPtr, rdPtr;
  logic [CNT_W-1:0] count;
  logic             doPush, doPop;

  assign queueFull = (count == CNT_W'(QUEUE_DEPTH));
  assign headValid = (count != '0);
  assign doPush    = inEn && !queueFull; // issuer honours queueFull anyway
  assign doPop     = pop && headValid;

  assign headOp  = opMem[rdPtr];
  assign headA   = aMem[rdPtr];
  assign headB   = bMem[rdPtr];
  assign headReg = regMem[rdPtr];
  assign headTag = tagMem[rdPtr];

  always_ff @(posedge clk) begin
    if (doPush) begin
      opMem[wrPtr]  <= inOp;
      aMem[wrPtr]   <= inA;
      bMem[wrPtr]   <= inB;
      regMem[wrPtr] <= inReg;
      tagMem[wrPtr] <= inTag;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush)
        wrPtr <= (wrPtr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      if (doPop)
        rdPtr <= (rdPtr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      count <= count + CNT_W'(doPush) - CNT_W'(doPop); // both may happen at once
    end
  end

endmodule

//--- rtDecode.sv
// *********************************************************************
// decode stage: unpacks the queue head, classifies special operands
// and starts the lowest free iterative unit
// *********************************************************************

`timescale 1ns/1ps

module rtDecode #(
  parameter int NUM_UNITS = 3
) (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   flush,
  input  logic                                   headValid,
  input  fpRootDivPkg::rtOp_e                    headOp,
  input  logic [31:0]                            headA,
  input  logic [31:0]                            headB,
  input  logic [fpRootDivPkg::REG_WIDTH-1:0]     headReg,
  input  logic [fpRootDivPkg::TAG_WIDTH-1:0]     headTag,
  input  logic [NUM_UNITS-1:0]                   idle,
  output logic                                   pop,
  output logic [NUM_UNITS-1:0]                   start,
  output fpRootDivPkg::rtOp_e                    decOp,
  output logic                                   decSign,
  output logic signed [fpRootDivPkg::EXP_WIDTH-1:0] decExp,
  output logic [fpRootDivPkg::MANT_WIDTH-1:0]    decMantA,
  output logic [fpRootDivPkg::MANT_WIDTH-1:0]    decMantB,
  output logic [fpRootDivPkg::CLASS_WIDTH-1:0]   decClass,
  output logic [fpRootDivPkg::REG_WIDTH-1:0]     decReg,
  output logic [fpRootDivPkg::TAG_WIDTH-1:0]     decTag
);
  import fpRootDivPkg::*;

  logic [NUM_UNITS-1:0]         avail, pick;
  logic [7:0]                   expA, expB;
  logic signed [EXP_WIDTH-1:0]  divExp, rootExp;
  logic [CLASS_WIDTH-1:0]       nextClass;

  // unit started last cycle still shows idle, keep it out
  assign avail = idle & ~start;
  assign pick  = avail & (~avail + NUM_UNITS'(1)); // lowest set bit
  assign pop   = headValid && (avail != '0);

  assign expA    = headA[30:23];
  assign expB    = headB[30:23];
  assign divExp  = $signed({2'b00, expA}) - $signed({2'b00, expB});
  assign rootExp = $signed({2'b00, expA}) - 10'sd127;

  always_comb begin
    nextClass = CLASS_NORMAL;
    if (headOp == opDiv) begin
      if (expB == 8'd0)
        nextClass = CLASS_DIVZERO;
      else if (expA == 8'd0)
        nextClass = CLASS_ZERO;
    end else begin
      if (expA == 8'd0)
        nextClass = CLASS_ZERO; // zero wins over the sign check
      else if (headA[31])
        nextClass = CLASS_INVALID;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush)
      start <= '0;
    else
      start <= pop ? pick : '0;
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      decOp    <= headOp;
      decClass <= nextClass;
      decReg   <= headReg;
      decTag   <= headTag;
      decMantB <= {2'b01, headB[22:0], 1'b0};
      if (headOp == opDiv) begin
        decSign  <= headA[31] ^ headB[31];
        decExp   <= divExp;
        decMantA <= {2'b01, headA[22:0], 1'b0};
      end else begin
        decSign <= 1'b0;
        // odd exponent: move one power of two into the mantissa, then halve
        decExp  <= {rootExp[EXP_WIDTH-1], rootExp[EXP_WIDTH-1:1]};
        if (rootExp[0])
          decMantA <= {1'b1, headA[22:0], 2'b00};
        else
          decMantA <= {2'b01, headA[22:0], 1'b0};
      end
    end
  end

endmodule

//--- rtIterUnit.sv
// *********************************************************************
// iterative unit: radix-2 restoring divide and bit-by-bit square root
// one result bit per cycle, result held until taken
// *********************************************************************

`timescale 1ns/1ps

module rtIterUnit (
  input  logic                                      clk,
  input  logic                                      rst,
  input  logic                                      flush,
  input  logic                                      start,
  input  fpRootDivPkg::rtOp_e                       decOp,
  input  logic                                      decSign,
  input  logic signed [fpRootDivPkg::EXP_WIDTH-1:0] decExp,
  input  logic [fpRootDivPkg::MANT_WIDTH-1:0]       decMantA,
  input  logic [fpRootDivPkg::MANT_WIDTH-1:0]       decMantB,
  input  logic [fpRootDivPkg::CLASS_WIDTH-1:0]      decClass,
  input  logic [fpRootDivPkg::REG_WIDTH-1:0]        decReg,
  input  logic [fpRootDivPkg::TAG_WIDTH-1:0]        decTag,
  input  logic                                      take,
  output logic                                      idle,
  output logic                                      done,
  output logic [31:0]                               res,
  output logic [fpRootDivPkg::REG_WIDTH-1:0]        resReg,
  output logic [fpRootDivPkg::TAG_WIDTH-1:0]        resTag,
  output fpRootDivPkg::rtOp_e                       resOp,
  output logic                                      resInvalid,
  output logic                                      resDivZero
);
  import fpRootDivPkg::*;

  localparam int CNT_W = $clog2(MANT_STEPS);
  localparam int REM_W = MANT_WIDTH + 1;

  unitState_e                  state;
  logic [CNT_W-1:0]            cnt;
  logic                        signReg;
  logic signed [EXP_WIDTH-1:0] expReg;
  logic [CLASS_WIDTH-1:0]      classReg;
  logic [REM_W-1:0]            rem;     // partial remainder
  logic [MANT_WIDTH-1:0]       q;       // quotient or root bits so far
  logic [MANT_WIDTH-1:0]       x;       // radicand, two bits used per step
  logic [MANT_WIDTH-1:0]       d;       // divisor

  logic                        divGe, sqrtGe;
  logic [REM_W+1:0]            sqrtCur, sqrtTrial;
  logic                        normShift;
  logic signed [EXP_WIDTH-1:0] biasedExp;
  logic [22:0]                 frac;

  // divide step
  assign divGe = rem >= {1'b0, d};

  // root step: bring down two radicand bits, try 4q+1
  assign sqrtCur   = {rem, x[MANT_WIDTH-1 -: 2]};
  assign sqrtTrial = {1'b0, q, 2'b01};
  assign sqrtGe    = sqrtCur >= sqrtTrial;

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      state <= stIdle;
      cnt   <= '0;
    end else begin
      case (state)
        stIdle: if (start) begin
          cnt   <= '0;
          state <= (decClass == CLASS_NORMAL) ? stIter : stDone;
        end
        stIter: begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_W'(MANT_STEPS - 1))
            state <= stDone;
        end
        stDone: if (take) state <= stIdle;
        default: state <= stIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == stIdle && start) begin
      resOp    <= decOp;
      signReg  <= decSign;
      expReg   <= decExp;
      classReg <= decClass;
      resReg   <= decReg;
      resTag   <= decTag;
      d        <= decMantB;
      x        <= decMantA;
      q        <= '0;
      rem      <= (decOp == opDiv) ? {1'b0, decMantA} : '0;
    end else if (state == stIter) begin
      if (resOp == opDiv) begin
        rem <= divGe ? (rem - {1'b0, d}) << 1 : rem << 1;
        q   <= {q[MANT_WIDTH-2:0], divGe};
      end else begin
        rem <= sqrtGe ? REM_W'(sqrtCur - sqrtTrial) : REM_W'(sqrtCur);
        q   <= {q[MANT_WIDTH-2:0], sqrtGe};
        x   <= x << 2;
      end
    end
  end

  // a divide quotient below one needs one place of normalization
  assign normShift = (resOp == opDiv) && !q[MANT_WIDTH-1];
  assign biasedExp = expReg + (normShift ? 10'sd126 : 10'sd127);
  assign frac      = normShift ? q[MANT_WIDTH-3:1] : q[MANT_WIDTH-2:2];

  always_comb begin
    case (classReg)
      CLASS_DIVZERO: res = {signReg, 8'hFF, 23'd0};
      CLASS_INVALID: res = QNAN_VALUE;
      CLASS_ZERO:    res = {signReg, 31'd0};
      default:       res = {signReg, biasedExp[7:0], frac}; // truncated
    endcase
  end

  assign idle       = (state == stIdle);
  assign done       = (state == stDone);
  assign resInvalid = (classReg == CLASS_INVALID);
  assign resDivZero = (classReg == CLASS_DIVZERO);

endmodule

//--- rtResultSel.sv
// *********************************************************************
// result stage: lowest-index finished unit wins the output port
// *********************************************************************

`timescale 1ns/1ps

module rtResultSel #(
  parameter int NUM_UNITS = 3
) (
  input  logic                                         clk,
  input  logic                                         rst,
  input  logic                                         flush,
  input  logic [NUM_UNITS-1:0]                         done,
  input  logic [NUM_UNITS*32-1:0]                      res,
  input  logic [NUM_UNITS*fpRootDivPkg::REG_WIDTH-1:0] resReg,
  input  logic [NUM_UNITS*fpRootDivPkg::TAG_WIDTH-1:0] resTag,
  input  logic [NUM_UNITS-1:0]                         resOp,
  input  logic [NUM_UNITS-1:0]                         resInvalid,
  input  logic [NUM_UNITS-1:0]                         resDivZero,
  output logic [NUM_UNITS-1:0]                         take,
  output logic                                         outEn,
  output logic [31:0]                                  outRes,
  output logic [fpRootDivPkg::REG_WIDTH-1:0]           outReg,
  output logic [fpRootDivPkg::TAG_WIDTH-1:0]           outTag,
  output fpRootDivPkg::rtOp_e                          outOp,
  output logic                                         outInvalid,
  output logic                                         outDivZero
);
  import fpRootDivPkg::*;

  int winIdx;

  assign take = done & (~done + NUM_UNITS'(1)); // one-hot of lowest done

  always_comb begin
    winIdx = 0;
    for (int i = NUM_UNITS - 1; i >= 0; i--)
      if (done[i]) winIdx = i;
  end

  always_ff @(posedge clk) begin
    if (rst || flush)
      outEn <= 1'b0;
    else
      outEn <= (done != '0);
  end

  always_ff @(posedge clk) begin
    if (done != '0) begin
      outRes     <= res[winIdx*32 +: 32];
      outReg     <= resReg[winIdx*REG_WIDTH +: REG_WIDTH];
      outTag     <= resTag[winIdx*TAG_WIDTH +: TAG_WIDTH];
      outOp      <= rtOp_e'(resOp[winIdx]);
      outInvalid <= resInvalid[winIdx];
      outDivZero <= resDivZero[winIdx];
    end
  end

endmodule

//--- fpRootDivTop.sv
// *********************************************************************
// divide/square-root cluster top level
// queue, decode, NUM_UNITS iterative units and result select
// *********************************************************************

`timescale 1ns/1ps

module fpRootDivTop #(
  parameter int NUM_UNITS   = 3,
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               flush,
  input  logic                               inEn,
  input  fpRootDivPkg::rtOp_e                inOp,
  input  logic [31:0]                        inA,
  input  logic [31:0]                        inB,
  input  logic [fpRootDivPkg::REG_WIDTH-1:0] inReg,
  input  logic [fpRootDivPkg::TAG_WIDTH-1:0] inTag,
  output logic                               queueFull,
  output logic                               outEn,
  output logic [31:0]                        outRes,
  output logic [fpRootDivPkg::REG_WIDTH-1:0] outReg,
  output logic [fpRootDivPkg::TAG_WIDTH-1:0] outTag,
  output fpRootDivPkg::rtOp_e                outOp,
  output logic                               outInvalid,
  output logic                               outDivZero
);
  import fpRootDivPkg::*;

  // queue head
  logic                 headValid, pop;
  rtOp_e                headOp;
  logic [31:0]          headA, headB;
  logic [REG_WIDTH-1:0] headReg;
  logic [TAG_WIDTH-1:0] headTag;

  // decoded operation, shared by all units
  logic [NUM_UNITS-1:0]        start, idle;
  rtOp_e                       decOp;
  logic                        decSign;
  logic signed [EXP_WIDTH-1:0] decExp;
  logic [MANT_WIDTH-1:0]       decMantA, decMantB;
  logic [CLASS_WIDTH-1:0]      decClass;
  logic [REG_WIDTH-1:0]        decReg;
  logic [TAG_WIDTH-1:0]        decTag;

  // per-unit results, flattened
  logic [NUM_UNITS-1:0]           done, take, unitOp, unitInvalid, unitDivZero;
  logic [NUM_UNITS*32-1:0]        unitRes;
  logic [NUM_UNITS*REG_WIDTH-1:0] unitReg;
  logic [NUM_UNITS*TAG_WIDTH-1:0] unitTag;

  opQueue #(.QUEUE_DEPTH(QUEUE_DEPTH)) opQueue_inst (
    .clk, .rst, .flush, .inEn, .inOp, .inA, .inB, .inReg, .inTag, .pop,
    .queueFull, .headValid, .headOp, .headA, .headB, .headReg, .headTag
  );

  rtDecode #(.NUM_UNITS(NUM_UNITS)) rtDecode_inst (
    .clk, .rst, .flush, .headValid, .headOp, .headA, .headB, .headReg, .headTag,
    .idle, .pop, .start, .decOp, .decSign, .decExp, .decMantA, .decMantB,
    .decClass, .decReg, .decTag
  );

  for (genvar i = 0; i < NUM_UNITS; i++) begin : genUnit
    rtIterUnit rtIterUnit_inst (
      .clk, .rst, .flush, .start(start[i]), .decOp, .decSign, .decExp,
      .decMantA, .decMantB, .decClass, .decReg, .decTag, .take(take[i]),
      .idle(idle[i]), .done(done[i]), .res(unitRes[i*32 +: 32]),
      .resReg(unitReg[i*REG_WIDTH +: REG_WIDTH]),
      .resTag(unitTag[i*TAG_WIDTH +: TAG_WIDTH]), .resOp(unitOp[i]),
      .resInvalid(unitInvalid[i]), .resDivZero(unitDivZero[i])
    );
  end

  rtResultSel #(.NUM_UNITS(NUM_UNITS)) rtResultSel_inst (
    .clk, .rst, .flush, .done, .res(unitRes), .resReg(unitReg), .resTag(unitTag),
    .resOp(unitOp), .resInvalid(unitInvalid), .resDivZero(unitDivZero), .take,
    .outEn, .outRes, .outReg, .outTag, .outOp, .outInvalid, .outDivZero
  );

endmodule

//--- fpRootDivProperties_properties.sv
// *********************************************************************
// concurrent assertions on the cluster top level, bound to fpRootDivTop
// *********************************************************************

`timescale 1ns/1ps

module fpRootDivProperties #(
  parameter int NUM_UNITS = 3
) (
  input logic                 clk,
  input logic                 rst,
  input logic                 inEn,
  input logic                 queueFull,
  input logic                 outEn,
  input logic [31:0]          outRes,
  input logic                 outInvalid,
  input logic                 outDivZero,
  input logic [NUM_UNITS-1:0] take
);
  import fpRootDivPkg::*;

  int failCount = 0;

  noIssueWhenFull: assert property (@(posedge clk) disable iff (rst) !(inEn && queueFull))
    else begin
      failCount++;
      $error("inEn high while queueFull is high");
    end

  quietAfterReset: assert property (@(posedge clk) rst |=> !outEn)
    else begin
      failCount++;
      $error("outEn high in the cycle after reset");
    end

  // a taken unit is idle again by the next edge
  takeOneHot: assert property (@(posedge clk) disable iff (rst)
      $onehot0(take) && ((take & $past(take)) == '0))
    else begin
      failCount++;
      $error("take not one-hot, or a taken unit stayed done");
    end

  // a result carries one flag at most, each with its special word
  flagsExclusive: assert property (@(posedge clk) disable iff (rst)
      outEn |-> !(outInvalid && outDivZero) && (!outInvalid || (outRes == QNAN_VALUE))
          && (!outDivZero || (outRes[30:0] == 31'h7F800000)))
    else begin
      failCount++;
      $error("outInvalid and outDivZero both high, or a flag without its result word");
    end

endmodule

bind fpRootDivTop fpRootDivProperties #(.NUM_UNITS(NUM_UNITS)) propsInst (
  .clk, .rst, .inEn, .queueFull, .outEn, .outRes, .outInvalid, .outDivZero, .take
);

//--- tbFpRootDiv.sv
// *********************************************************************
// directed testbench for the divide/square-root cluster
// clock, reset, issue, result wait, compare tasks and a tag scoreboard
// *********************************************************************

`timescale 1ns/1ps

module tbFpRootDiv;
  import fpRootDivPkg::*;

  localparam int NUM_UNITS      = 3;
  localparam int QUEUE_DEPTH    = 4;
  localparam int NUM_VECTORS    = 9;
  localparam int TAG_SPACE      = 1 << TAG_WIDTH;
  localparam int RESULT_TIMEOUT = 200;
  localparam int FULL_TIMEOUT   = 200;
  localparam int FLUSH_QUIET    = 100;

  logic                 clk, rst, flush, inEn, queueFull, outEn, outInvalid, outDivZero;
  rtOp_e                inOp, outOp;
  logic [31:0]          inA, inB, outRes;
  logic [REG_WIDTH-1:0] inReg, outReg;
  logic [TAG_WIDTH-1:0] inTag, outTag;

  // op, a, b, expected word, {invalid, divZero}
  logic [98:0] vectors [NUM_VECTORS];

  // scoreboard, indexed by tag
  logic                 pending  [TAG_SPACE];
  logic [31:0]          expRes   [TAG_SPACE];
  logic [REG_WIDTH-1:0] expReg   [TAG_SPACE];
  rtOp_e                expOp    [TAG_SPACE];
  logic [1:0]           expFlags [TAG_SPACE];

  // last result seen on the output port
  logic [31:0]          gotRes;
  logic [REG_WIDTH-1:0] gotReg;
  logic [TAG_WIDTH-1:0] gotTag;
  rtOp_e                gotOp;
  logic [1:0]           gotFlags;

  int seed = 42067;

  fpRootDivTop #(.NUM_UNITS(NUM_UNITS), .QUEUE_DEPTH(QUEUE_DEPTH)) fpRootDivTop_inst (
    .clk, .rst, .flush, .inEn, .inOp, .inA, .inB, .inReg, .inTag, .queueFull,
    .outEn, .outRes, .outReg, .outTag, .outOp, .outInvalid, .outDivZero
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic failRun(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic checkRes(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) failRun($sformatf("FAILED %s: got %h expected %h", name, got, exp));
  endtask

  task automatic checkReg(input string name, input logic [REG_WIDTH-1:0] got,
                          input logic [REG_WIDTH-1:0] exp);
    if (got !== exp) failRun($sformatf("FAILED %s: got %h expected %h", name, got, exp));
  endtask

  task automatic checkTag(input string name, input logic [TAG_WIDTH-1:0] got,
                          input logic [TAG_WIDTH-1:0] exp);
    if (got !== exp) failRun($sformatf("FAILED %s: got %h expected %h", name, got, exp));
  endtask

  task automatic checkFlags(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) failRun($sformatf("FAILED %s: got %h expected %h", name, got, exp));
  endtask

  task automatic checkOp(input string name, input rtOp_e got, input rtOp_e exp);
    if (got !== exp) failRun($sformatf("FAILED %s: got %h expected %h", name, got, exp));
  endtask

  task automatic checkLevel(input string name, input logic got, input logic exp);
    if (got !== exp) failRun($sformatf("FAILED %s: got %h expected %h", name, got, exp));
  endtask

  task automatic loadVectors();
    vectors[0] = {opDiv,  32'h40C00000, 32'h40000000, 32'h40400000, 2'b00}; // 6 / 2
    vectors[1] = {opDiv,  32'hC0F00000, 32'h40200000, 32'hC0400000, 2'b00}; // -7.5 / 2.5
    vectors[2] = {opSqrt, 32'h41800000, 32'h00000000, 32'h40800000, 2'b00}; // sqrt 16
    vectors[3] = {opSqrt, 32'h40100000, 32'h00000000, 32'h3FC00000, 2'b00}; // sqrt 2.25
    vectors[4] = {opSqrt, 32'h3E800000, 32'h00000000, 32'h3F000000, 2'b00}; // sqrt 0.25
    vectors[5] = {opDiv,  32'h40A00000, 32'h00000000, 32'h7F800000, 2'b01}; // 5 / 0
    vectors[6] = {opDiv,  32'hC0A00000, 32'h00000000, 32'hFF800000, 2'b01}; // -5 / 0
    vectors[7] = {opSqrt, 32'hC0800000, 32'h00000000, QNAN_VALUE,   2'b10}; // sqrt -4
    vectors[8] = {opDiv,  32'h00000000, 32'h40400000, 32'h00000000, 2'b00}; // 0 / 3
    for (int t = 0; t < TAG_SPACE; t++)
      pending[t] = 1'b0;
  endtask

  // random tag not currently outstanding
  function automatic logic [TAG_WIDTH-1:0] newTag();
    logic [TAG_WIDTH-1:0] t;
    t = TAG_WIDTH'($random(seed));
    while (pending[t])
      t = t + 1'b1;
    return t;
  endfunction

  task automatic issueOp(input int idx, input logic [TAG_WIDTH-1:0] tag);
    logic [98:0]          v;
    logic [REG_WIDTH-1:0] regNum;
    int                   cycles;
    v      = vectors[idx];
    regNum = REG_WIDTH'($random(seed));
    cycles = 0;
    @(negedge clk);
    while (queueFull && cycles < FULL_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (queueFull) failRun("timeout: queueFull never dropped");
    pending[tag]  = 1'b1;
    expRes[tag]   = v[33:2];
    expReg[tag]   = regNum;
    expOp[tag]    = rtOp_e'(v[98]);
    expFlags[tag] = v[1:0];
    @(posedge clk);
    inEn  <= 1'b1;
    inOp  <= rtOp_e'(v[98]);
    inA   <= v[97:66];
    inB   <= v[65:34];
    inReg <= regNum;
    inTag <= tag;
    @(posedge clk);
    inEn <= 1'b0; // push lands on this edge
  endtask

  task automatic waitResult();
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < RESULT_TIMEOUT) begin
      @(negedge clk);
      cycles++;
      if (outEn) begin
        seen     = 1'b1;
        gotRes   = outRes;
        gotReg   = outReg;
        gotTag   = outTag;
        gotOp    = outOp;
        gotFlags = {outInvalid, outDivZero};
      end
    end
    if (!seen) failRun("timeout: no result came out of the DUT");
  endtask

  // match the captured result against the scoreboard entry of its tag
  task automatic scoreResult();
    if (pending[gotTag] !== 1'b1)
      failRun($sformatf("result returned for tag %h which was not outstanding", gotTag));
    checkRes("outRes", gotRes, expRes[gotTag]);
    checkReg("outReg", gotReg, expReg[gotTag]);
    checkOp("outOp", gotOp, expOp[gotTag]);
    checkFlags("{outInvalid, outDivZero}", gotFlags, expFlags[gotTag]);
    pending[gotTag] = 1'b0;
  endtask

  task automatic runVector(input int idx);
    logic [TAG_WIDTH-1:0] tag;
    tag = newTag();
    issueOp(idx, tag);
    waitResult();
    checkTag("outTag", gotTag, tag);
    scoreResult();
  endtask

  task automatic testDivide();
    runVector(0);
    runVector(1);
  endtask

  task automatic testRoot();
    runVector(2);
    runVector(3); // odd exponent
    runVector(4);
  endtask

  task automatic testSpecial();
    for (int i = 5; i < NUM_VECTORS; i++)
      runVector(i);
  endtask

  // results come back out of order, scoreboard matches them by tag
  task automatic testBurst();
    fork
      begin
        for (int i = 0; i < NUM_UNITS + QUEUE_DEPTH; i++)
          issueOp($unsigned($random(seed)) % NUM_VECTORS, newTag());
      end
      begin
        for (int i = 0; i < NUM_UNITS + QUEUE_DEPTH; i++) begin
          waitResult();
          scoreResult();
        end
      end
    join
  endtask

  task automatic testFlush();
    int cycles;
    // long ops only, enough to fill every unit and then the queue
    for (int i = 0; i < NUM_UNITS + QUEUE_DEPTH; i++)
      issueOp(i % 5, newTag());
    @(negedge clk);
    checkLevel("queueFull", queueFull, 1'b1);
    @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    @(negedge clk);
    checkLevel("queueFull", queueFull, 1'b0); // queue emptied
    for (int t = 0; t < TAG_SPACE; t++)
      pending[t] = 1'b0;
    cycles = 0;
    while (cycles < FLUSH_QUIET) begin
      @(negedge clk);
      if (outEn) failRun("a result came out after flush");
      cycles++;
    end
    runVector(1);
  endtask

  initial begin
    rst   = 1'b1;
    flush = 1'b0;
    inEn  = 1'b0;
    inOp  = opDiv;
    inA   = '0;
    inB   = '0;
    inReg = '0;
    inTag = '0;
    loadVectors();
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    testDivide();
    testRoot();
    testSpecial();
    testBurst();
    testFlush();
    repeat (2) @(posedge clk);
    if (fpRootDivTop_inst.propsInst.failCount == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      failRun("concurrent assertions on the DUT failed");
    end
  end

endmodule

//--- src.f
fpRootDivPkg.sv
opQueue.sv
rtDecode.sv
rtIterUnit.sv
rtResultSel.sv
fpRootDivTop.sv
fpRootDivProperties_properties.sv
tbFpRootDiv.sv
